// File: project.f
+incdir+dv
common/tlb_pkg.sv
common/tlb_entry_if.sv
tlb/tlb_entry_array.sv
tlb/tlb_lookup.sv
tlb/tlb_invalidate.sv
verilog/tlb_top.sv
dv/tlb_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tlb_tb -f project.f --Mdir build -o tlb_sim
./build/tlb_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

// File: dv/tlb_ref_model.svh
`ifndef TLB_REF_MODEL_SVH
`define TLB_REF_MODEL_SVH

// shadow copy of the entry table, kept in step with every write and invalidation
typedef struct packed {
    logic       e;
    logic       g;
    vppn_t      vppn;
    asid_t      asid;
    ps_t        ps;
    logic [1:0] v;
    logic [1:0] d;
    mat_t [1:0] mat;
    plv_t [1:0] plv;
    ppn_t [1:0] ppn;
} entry_t;

typedef struct packed {
    logic          found;
    logic [IW-1:0] index;
    ps_t           ps;
    ppn_t          ppn;
    logic          v;
    logic          d;
    mat_t          mat;
    plv_t          plv;
} res_t;

entry_t shadow [TLB_NUM] = '{default: '0};

// huge pages only look at the upper vppn bits
function automatic logic page_match(entry_t ent, vppn_t vppn);
    if (ent.ps == PS_SMALL) begin
        return ent.vppn == vppn;
    end
    return ent.vppn[18:HUGE_VPPN_LSB] == vppn[18:HUGE_VPPN_LSB];
endfunction

function automatic res_t predict_lookup(vppn_t vppn, asid_t asid, logic odd_page);
    res_t res;
    logic half;
    res = '0;
    for (int i = 0; i < TLB_NUM; i++) begin
        if (shadow[i].e && (shadow[i].g || shadow[i].asid == asid)
                && page_match(shadow[i], vppn)) begin
            half = (shadow[i].ps == PS_SMALL) ? odd_page : vppn[HUGE_VPPN_LSB-1];
            res = '{1'b1, IW'(i), shadow[i].ps, shadow[i].ppn[half], shadow[i].v[half],
                    shadow[i].d[half], shadow[i].mat[half], shadow[i].plv[half]};
        end
    end
    return res;
endfunction

function automatic logic [TLB_NUM-1:0] predict_clear(inv_op_t op, asid_t asid, vppn_t vppn);
    logic [TLB_NUM-1:0] mask;
    logic g;
    logic same_asid;
    logic va;
    mask = '0;
    for (int i = 0; i < TLB_NUM; i++) begin
        g = shadow[i].g;
        same_asid = (shadow[i].asid == asid);
        va = page_match(shadow[i], vppn);
        case (op)
            INV_ALL0, INV_ALL1:    mask[i] = 1'b1;
            INV_GLOBAL:            mask[i] = g;
            INV_NONGLOBAL:         mask[i] = !g;
            INV_ASID:              mask[i] = !g && same_asid;
            INV_ASID_VA:           mask[i] = !g && same_asid && va;
            INV_GLOBAL_OR_ASID_VA: mask[i] = (g || same_asid) && va;
            default:               mask[i] = 1'b0;
        endcase
    end
    return mask;
endfunction

`endif

// File: dv/tlb_tb.sv
module tlb_tb
    import tlb_pkg::*;
();

    localparam int TLB_NUM    = 32;
    localparam int IW         = $clog2(TLB_NUM);
    localparam int SEED       = 80522;
    // the sequence below takes about 920 cycles
    localparam int MAX_CYCLES = 3000;

    `include "tlb_ref_model.svh"

    localparam int FW = $bits(entry_t) - 1;

    logic clk = 1'b0;
    logic rst_n;
    logic s0_valid, s0_odd_page, s0_found, s0_v, s0_d;
    logic s1_valid, s1_odd_page, s1_found, s1_v, s1_d;
    logic we, w_g, w_e, w_v0, w_d0, w_v1, w_d1;
    logic r_g, r_e, r_v0, r_d0, r_v1, r_d1;
    logic inv_en;
    logic [IW-1:0] s0_index, s1_index, w_index, r_index;
    vppn_t   s0_vppn, s1_vppn, w_vppn, r_vppn, inv_vppn;
    asid_t   s0_asid, s1_asid, w_asid, r_asid, inv_asid;
    ps_t     s0_ps, s1_ps, w_ps, r_ps;
    ppn_t    s0_ppn, s1_ppn, w_ppn0, w_ppn1, r_ppn0, r_ppn1;
    mat_t    s0_mat, s1_mat, w_mat0, w_mat1, r_mat0, r_mat1;
    plv_t    s0_plv, s1_plv, w_plv0, w_plv1, r_plv0, r_plv1;
    inv_op_t inv_op;

    logic   chk_lk, chk_rd, chk_fields;
    logic   chk_lk_q = 1'b0;
    res_t   exp0, exp1, got0, got1;
    res_t   exp0_q, exp1_q;
    entry_t exp_r, got_r;
    int     lookup_errors = 0;
    int     read_errors = 0;
    int     cycles = 0;

    tlb_top #(.TLB_NUM(TLB_NUM)) tlb_top_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // the match register takes the request one edge after it is driven
    always @(posedge clk) begin
        chk_lk_q <= chk_lk;
        exp0_q <= exp0;
        exp1_q <= exp1;
    end

    assign got0 = {s0_found, s0_index, s0_ps, s0_ppn, s0_v, s0_d, s0_mat, s0_plv};
    assign got1 = {s1_found, s1_index, s1_ps, s1_ppn, s1_v, s1_d, s1_mat, s1_plv};
    assign got_r = {r_e, r_g, r_vppn, r_asid, r_ps, r_v1, r_v0, r_d1, r_d0,
                    r_mat1, r_mat0, r_plv1, r_plv0, r_ppn1, r_ppn0};

    // results one cycle after the request
    assert property (@(posedge clk) !chk_lk_q || got0 == exp0_q)
        else begin
            lookup_errors++;
            diff_lookup("s0", $sampled(got0), $sampled(exp0_q));
        end
    assert property (@(posedge clk) !chk_lk_q || got1 == exp1_q)
        else begin
            lookup_errors++;
            diff_lookup("s1", $sampled(got1), $sampled(exp1_q));
        end
    assert property (@(posedge clk) !chk_rd || got_r.e == exp_r.e)
        else begin
            read_errors++;
            show_mismatch("r_e", 64'($sampled(got_r.e)), 64'($sampled(exp_r.e)));
        end
    assert property (@(posedge clk) !chk_fields || got_r[FW-1:0] == exp_r[FW-1:0])
        else begin
            read_errors++;
            diff_read($sampled(got_r), $sampled(exp_r));
        end

    task automatic show_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail t=%0t %s: got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic diff_lookup(string port, res_t got, res_t exp);
        show_mismatch({port, "_found"}, 64'(got.found), 64'(exp.found));
        show_mismatch({port, "_index"}, 64'(got.index), 64'(exp.index));
        show_mismatch({port, "_ps"}, 64'(got.ps), 64'(exp.ps));
        show_mismatch({port, "_ppn"}, 64'(got.ppn), 64'(exp.ppn));
        show_mismatch({port, "_v"}, 64'(got.v), 64'(exp.v));
        show_mismatch({port, "_d"}, 64'(got.d), 64'(exp.d));
        show_mismatch({port, "_mat"}, 64'(got.mat), 64'(exp.mat));
        show_mismatch({port, "_plv"}, 64'(got.plv), 64'(exp.plv));
    endtask

    task automatic diff_read(entry_t got, entry_t exp);
        show_mismatch("r_g", 64'(got.g), 64'(exp.g));
        show_mismatch("r_vppn", 64'(got.vppn), 64'(exp.vppn));
        show_mismatch("r_asid", 64'(got.asid), 64'(exp.asid));
        show_mismatch("r_ps", 64'(got.ps), 64'(exp.ps));
        show_mismatch("{r_v1, r_v0}", 64'(got.v), 64'(exp.v));
        show_mismatch("{r_d1, r_d0}", 64'(got.d), 64'(exp.d));
        show_mismatch("{r_mat1, r_mat0}", 64'(got.mat), 64'(exp.mat));
        show_mismatch("{r_plv1, r_plv0}", 64'(got.plv), 64'(exp.plv));
        show_mismatch("{r_ppn1, r_ppn0}", 64'(got.ppn), 64'(exp.ppn));
    endtask

    task automatic quiet();
        s0_valid <= 1'b0;
        s1_valid <= 1'b0;
        we <= 1'b0;
        inv_en <= 1'b0;
        chk_lk <= 1'b0;
        chk_rd <= 1'b0;
        chk_fields <= 1'b0;
    endtask

    task automatic put_write(int idx, entry_t ent);
        w_index <= IW'(idx);
        w_e <= ent.e;
        w_g <= ent.g;
        w_vppn <= ent.vppn;
        w_asid <= ent.asid;
        w_ps <= ent.ps;
        w_v0 <= ent.v[0];
        w_v1 <= ent.v[1];
        w_d0 <= ent.d[0];
        w_d1 <= ent.d[1];
        w_mat0 <= ent.mat[0];
        w_mat1 <= ent.mat[1];
        w_plv0 <= ent.plv[0];
        w_plv1 <= ent.plv[1];
        w_ppn0 <= ent.ppn[0];
        w_ppn1 <= ent.ppn[1];
    endtask

    task automatic put_lookup(vppn_t vppn0, asid_t asid0, logic odd0,
                              vppn_t vppn1, asid_t asid1, logic odd1);
        s0_vppn <= vppn0;
        s0_asid <= asid0;
        s0_odd_page <= odd0;
        s1_vppn <= vppn1;
        s1_asid <= asid1;
        s1_odd_page <= odd1;
    endtask

    task automatic put_inv(inv_op_t op, asid_t asid, vppn_t vppn);
        inv_op <= op;
        inv_asid <= asid;
        inv_vppn <= vppn;
    endtask

    // write and invalidation in one cycle, the write wins for its own entry
    task automatic update(logic do_we, int idx, entry_t ent, logic do_inv, inv_op_t op,
                          asid_t asid, vppn_t vppn);
        logic [TLB_NUM-1:0] mask;
        @(posedge clk);
        quiet();
        mask = do_inv ? predict_clear(op, asid, vppn) : '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (mask[i]) begin
                shadow[i].e = 1'b0;
            end
        end
        if (do_we) begin
            shadow[idx] = ent;
        end
        we <= do_we;
        put_write(idx, ent);
        inv_en <= do_inv;
        put_inv(op, asid, vppn);
    endtask

    task automatic lookup(vppn_t vppn0, asid_t asid0, logic odd0,
                          vppn_t vppn1, asid_t asid1, logic odd1);
        @(posedge clk);
        quiet();
        s0_valid <= 1'b1;
        s1_valid <= 1'b1;
        put_lookup(vppn0, asid0, odd0, vppn1, asid1, odd1);
        exp0 <= predict_lookup(vppn0, asid0, odd0);
        exp1 <= predict_lookup(vppn1, asid1, odd1);
        chk_lk <= 1'b1;
    endtask

    task automatic read_check(int idx, logic fields);
        @(posedge clk);
        quiet();
        r_index <= IW'(idx);
        exp_r <= shadow[idx];
        chk_rd <= 1'b1;
        chk_fields <= fields;
    endtask

    // the index sits in the top vppn bits, so no request can hit two entries
    function automatic entry_t random_entry(int idx);
        entry_t ent;
        ent.e = ($urandom_range(0, 7) != 0);
        ent.g = ($urandom_range(0, 3) == 0);
        ent.vppn = vppn_t'($urandom);
        ent.vppn[18 -: IW] = IW'(idx);
        ent.asid = asid_t'($urandom_range(0, 3));
        ent.ps = ($urandom_range(0, 1) == 1) ? PS_HUGE : PS_SMALL;
        ent.v = 2'($urandom);
        ent.d = 2'($urandom);
        ent.mat = 4'($urandom);
        ent.plv = 4'($urandom);
        ent.ppn = {ppn_t'($urandom), ppn_t'($urandom)};
        return ent;
    endfunction

    // huge entries get random low bits, which also picks the half
    function automatic vppn_t request_vppn(int idx);
        vppn_t req;
        req = shadow[idx].vppn;
        if (shadow[idx].ps == PS_HUGE) begin
            req[HUGE_VPPN_LSB-1:0] = HUGE_VPPN_LSB'($urandom);
        end
        return req;
    endfunction

    task automatic refill();
        for (int i = 0; i < TLB_NUM; i++) begin
            update(1'b1, i, random_entry(i), 1'b0, INV_ALL0, '0, '0);
        end
    endtask

    initial begin
        int t;
        int k;
        entry_t ent;
        void'($urandom(SEED));
        rst_n <= 1'b0;
        quiet();
        put_write(0, '0);
        put_lookup('0, '0, 1'b0, '0, '0, 1'b0);
        put_inv(INV_ALL0, '0, '0);
        r_index <= '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < TLB_NUM; i++) begin
            read_check(i, 1'b0);
        end
        repeat (8) begin
            lookup(vppn_t'($urandom), asid_t'($urandom), 1'b0,
                   vppn_t'($urandom), asid_t'($urandom), 1'b1);
        end

        refill();
        for (int i = 0; i < TLB_NUM; i++) begin
            read_check(i, 1'b1);
        end
        // port 1 uses a foreign asid, so only global entries hit there
        for (int i = 0; i < TLB_NUM; i++) begin
            k = (i + 5) % TLB_NUM;
            lookup(request_vppn(i), shadow[i].asid, 1'($urandom),
                   request_vppn(k), shadow[k].asid ^ 10'h200, 1'($urandom));
        end

        // codes 0 to 6 plus one reserved code
        for (int op = 0; op < 8; op++) begin
            refill();
            t = $urandom_range(0, TLB_NUM - 1);
            k = (t + 1) % TLB_NUM;
            ent = random_entry(k);
            ent.e = 1'b1;
            update(1'b1, k, ent, 1'b1, inv_op_t'(op), shadow[t].asid, request_vppn(t));
            for (int i = 0; i < TLB_NUM; i++) begin
                read_check(i, 1'b1);
            end
            for (int i = 0; i < TLB_NUM; i++) begin
                lookup(request_vppn(i), shadow[i].asid, 1'b0,
                       request_vppn(i), shadow[i].asid, 1'b1);
            end
        end

        @(posedge clk);
        quiet();
        repeat (2) @(posedge clk);
        $display("errors: lookup %0d, read %0d, total %0d",
                 lookup_errors, read_errors, lookup_errors + read_errors);
        if (lookup_errors + read_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/tlb_top.sv
module tlb_top
    import tlb_pkg::*;
#(
    parameter int TLB_NUM = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // fetch lookup
    input  logic                       s0_valid,
    input  vppn_t                      s0_vppn,
    input  asid_t                      s0_asid,
    input  logic                       s0_odd_page,
    output logic                       s0_found,
    output logic [$clog2(TLB_NUM)-1:0] s0_index,
    output ps_t                        s0_ps,
    output ppn_t                       s0_ppn,
    output logic                       s0_v,
    output logic                       s0_d,
    output mat_t                       s0_mat,
    output plv_t                       s0_plv,

    // data lookup
    input  logic                       s1_valid,
    input  vppn_t                      s1_vppn,
    input  asid_t                      s1_asid,
    input  logic                       s1_odd_page,
    output logic                       s1_found,
    output logic [$clog2(TLB_NUM)-1:0] s1_index,
    output ps_t                        s1_ps,
    output ppn_t                       s1_ppn,
    output logic                       s1_v,
    output logic                       s1_d,
    output mat_t                       s1_mat,
    output plv_t                       s1_plv,

    input  logic                       we,
    input  logic [$clog2(TLB_NUM)-1:0] w_index,
    input  vppn_t                      w_vppn,
    input  asid_t                      w_asid,
    input  logic                       w_g,
    input  ps_t                        w_ps,
    input  logic                       w_e,
    input  logic                       w_v0,
    input  logic                       w_d0,
    input  mat_t                       w_mat0,
    input  plv_t                       w_plv0,
    input  ppn_t                       w_ppn0,
    input  logic                       w_v1,
    input  logic                       w_d1,
    input  mat_t                       w_mat1,
    input  plv_t                       w_plv1,
    input  ppn_t                       w_ppn1,

    input  logic [$clog2(TLB_NUM)-1:0] r_index,
    output vppn_t                      r_vppn,
    output asid_t                      r_asid,
    output logic                       r_g,
    output ps_t                        r_ps,
    output logic                       r_e,
    output logic                       r_v0,
    output logic                       r_d0,
    output mat_t                       r_mat0,
    output plv_t                       r_plv0,
    output ppn_t                       r_ppn0,
    output logic                       r_v1,
    output logic                       r_d1,
    output mat_t                       r_mat1,
    output plv_t                       r_plv1,
    output ppn_t                       r_ppn1,

    input  logic                       inv_en,
    input  inv_op_t                    inv_op,
    input  asid_t                      inv_asid,
    input  vppn_t                      inv_vppn
);

    logic [TLB_NUM-1:0] clear_mask;

    tlb_entry_if #(.TLB_NUM(TLB_NUM)) entries ();

    // port names match the top level one to one
    tlb_entry_array #(.TLB_NUM(TLB_NUM)) entry_array (.*);

    tlb_invalidate #(.TLB_NUM(TLB_NUM)) invalidate (.*);

    tlb_lookup #(.TLB_NUM(TLB_NUM)) lookup0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (s0_valid),
        .vppn     (s0_vppn),
        .asid     (s0_asid),
        .odd_page (s0_odd_page),
        .found    (s0_found),
        .index    (s0_index),
        .ps       (s0_ps),
        .ppn      (s0_ppn),
        .v        (s0_v),
        .d        (s0_d),
        .mat      (s0_mat),
        .plv      (s0_plv),
        .entries  (entries)
    );

    tlb_lookup #(.TLB_NUM(TLB_NUM)) lookup1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid    (s1_valid),
        .vppn     (s1_vppn),
        .asid     (s1_asid),
        .odd_page (s1_odd_page),
        .found    (s1_found),
        .index    (s1_index),
        .ps       (s1_ps),
        .ppn      (s1_ppn),
        .v        (s1_v),
        .d        (s1_d),
        .mat      (s1_mat),
        .plv      (s1_plv),
        .entries  (entries)
    );

endmodule

// File: tlb/tlb_invalidate.sv
module tlb_invalidate
    import tlb_pkg::*;
#(
    parameter int TLB_NUM = 32
) (
    input  logic               inv_en,
    input  inv_op_t            inv_op,
    input  asid_t              inv_asid,
    input  vppn_t              inv_vppn,

    output logic [TLB_NUM-1:0] clear_mask,

    tlb_entry_if.view          entries
);

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_entry
        logic asid_eq;
        logic va_eq;
        logic glob;
        logic sel;

        assign asid_eq = (entries.asid[i] == inv_asid);
        assign va_eq   = vppn_hit(entries.ps[i], entries.vppn[i], inv_vppn);
        assign glob    = entries.g[i];

        always_comb begin
            case (inv_op)
                INV_ALL0,
                INV_ALL1:              sel = 1'b1;
                INV_GLOBAL:            sel = glob;
                INV_NONGLOBAL:         sel = !glob;
                INV_ASID:              sel = !glob && asid_eq;
                INV_ASID_VA:           sel = !glob && asid_eq && va_eq;
                INV_GLOBAL_OR_ASID_VA: sel = (glob || asid_eq) && va_eq;
                // reserved codes leave the table alone
                default:               sel = 1'b0;
            endcase
        end

        assign clear_mask[i] = inv_en && sel;
    end

endmodule

// File: tlb/tlb_lookup.sv
module tlb_lookup
    import tlb_pkg::*;
#(
    parameter int TLB_NUM = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       valid,
    input  vppn_t                      vppn,
    input  asid_t                      asid,
    input  logic                       odd_page,

    output logic                       found,
    output logic [$clog2(TLB_NUM)-1:0] index,
    output ps_t                        ps,
    output ppn_t                       ppn,
    output logic                       v,
    output logic                       d,
    output mat_t                       mat,
    output plv_t                       plv,

    tlb_entry_if.view                  entries
);

    typedef logic [$clog2(TLB_NUM)-1:0] idx_t;

    logic [TLB_NUM-1:0] hit;
    logic [TLB_NUM-1:0] odd;
    logic [TLB_NUM-1:0] match_q;
    logic [TLB_NUM-1:0] odd_q;

    for (genvar i = 0; i < TLB_NUM; i++) begin : g_cmp
        assign hit[i] = entries.e[i]
                        && (entries.g[i] || (entries.asid[i] == asid))
                        && vppn_hit(entries.ps[i], entries.vppn[i], vppn);
        // huge pages take the half from the address itself
        assign odd[i] = (entries.ps[i] == PS_SMALL) ? odd_page : vppn[HUGE_VPPN_LSB-1];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            match_q <= '0;
        end else if (valid) begin
            match_q <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            odd_q <= odd;
        end
    end

    assign found = |match_q;

    // at most one entry matches, so OR-ing the selected fields is a mux
    always_comb begin
        index = '0;
        ps    = '0;
        ppn   = '0;
        v     = 1'b0;
        d     = 1'b0;
        mat   = '0;
        plv   = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (match_q[i]) begin
                index = index | idx_t'(i);
                ps    = ps | entries.ps[i];
                ppn   = ppn | entries.ppn[i][odd_q[i]];
                v     = v | entries.v[i][odd_q[i]];
                d     = d | entries.d[i][odd_q[i]];
                mat   = mat | entries.mat[i][odd_q[i]];
                plv   = plv | entries.plv[i][odd_q[i]];
            end
        end
    end

endmodule

// File: tlb/tlb_entry_array.sv
module tlb_entry_array
    import tlb_pkg::*;
#(
    parameter int TLB_NUM = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       we,
    input  logic [$clog2(TLB_NUM)-1:0] w_index,
    input  vppn_t                      w_vppn,
    input  asid_t                      w_asid,
    input  logic                       w_g,
    input  ps_t                        w_ps,
    input  logic                       w_e,
    input  logic                       w_v0,
    input  logic                       w_d0,
    input  mat_t                       w_mat0,
    input  plv_t                       w_plv0,
    input  ppn_t                       w_ppn0,
    input  logic                       w_v1,
    input  logic                       w_d1,
    input  mat_t                       w_mat1,
    input  plv_t                       w_plv1,
    input  ppn_t                       w_ppn1,

    input  logic [$clog2(TLB_NUM)-1:0] r_index,
    output vppn_t                      r_vppn,
    output asid_t                      r_asid,
    output logic                       r_g,
    output ps_t                        r_ps,
    output logic                       r_e,
    output logic                       r_v0,
    output logic                       r_d0,
    output mat_t                       r_mat0,
    output plv_t                       r_plv0,
    output ppn_t                       r_ppn0,
    output logic                       r_v1,
    output logic                       r_d1,
    output mat_t                       r_mat1,
    output plv_t                       r_plv1,
    output ppn_t                       r_ppn1,

    input  logic [TLB_NUM-1:0]         clear_mask,
    tlb_entry_if.store                 entries
);

    always_ff @(posedge clk) begin
        if (we) begin
            entries.vppn[w_index] <= w_vppn;
            entries.asid[w_index] <= w_asid;
            entries.g[w_index]    <= w_g;
            entries.ps[w_index]   <= w_ps;
            entries.v[w_index]    <= {w_v1, w_v0};
            entries.d[w_index]    <= {w_d1, w_d0};
            entries.mat[w_index]  <= {w_mat1, w_mat0};
            entries.plv[w_index]  <= {w_plv1, w_plv0};
            entries.ppn[w_index]  <= {w_ppn1, w_ppn0};
        end
    end

    // the write comes last so it wins over a clear of the same entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entries.e <= '0;
        end else begin
            entries.e <= entries.e & ~clear_mask;
            if (we) begin
                entries.e[w_index] <= w_e;
            end
        end
    end

    assign r_vppn = entries.vppn[r_index];
    assign r_asid = entries.asid[r_index];
    assign r_g    = entries.g[r_index];
    assign r_ps   = entries.ps[r_index];
    assign r_e    = entries.e[r_index];
    assign r_v0   = entries.v[r_index][0];
    assign r_d0   = entries.d[r_index][0];
    assign r_mat0 = entries.mat[r_index][0];
    assign r_plv0 = entries.plv[r_index][0];
    assign r_ppn0 = entries.ppn[r_index][0];
    assign r_v1   = entries.v[r_index][1];
    assign r_d1   = entries.d[r_index][1];
    assign r_mat1 = entries.mat[r_index][1];
    assign r_plv1 = entries.plv[r_index][1];
    assign r_ppn1 = entries.ppn[r_index][1];

endmodule

// File: common/tlb_entry_if.sv
interface tlb_entry_if
    import tlb_pkg::*;
#(
    parameter int TLB_NUM = 32
);

    logic  [TLB_NUM-1:0]      e;
    logic  [TLB_NUM-1:0]      g;
    vppn_t [TLB_NUM-1:0]      vppn;
    asid_t [TLB_NUM-1:0]      asid;
    ps_t   [TLB_NUM-1:0]      ps;

    // per entry, index 0 is the even page and 1 the odd page
    logic  [TLB_NUM-1:0][1:0] v;
    logic  [TLB_NUM-1:0][1:0] d;
    mat_t  [TLB_NUM-1:0][1:0] mat;
    plv_t  [TLB_NUM-1:0][1:0] plv;
    ppn_t  [TLB_NUM-1:0][1:0] ppn;

    modport store (
        output e, g, vppn, asid, ps, v, d, mat, plv, ppn
    );

    modport view (
        input e, g, vppn, asid, ps, v, d, mat, plv, ppn
    );

endinterface

// File: common/tlb_pkg.sv
package tlb_pkg;

    typedef logic [18:0] vppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  mat_t;
    typedef logic [1:0]  plv_t;
    typedef logic [4:0]  inv_op_t;

    // page sizes as log2 of the byte size
    localparam ps_t PS_SMALL = 6'd12;
    localparam ps_t PS_HUGE  = 6'd21;

    // huge pages ignore vppn bits below this one
    localparam int HUGE_VPPN_LSB = 9;

    localparam inv_op_t INV_ALL0              = 5'd0;
    localparam inv_op_t INV_ALL1              = 5'd1;
    localparam inv_op_t INV_GLOBAL            = 5'd2;
    localparam inv_op_t INV_NONGLOBAL         = 5'd3;
    localparam inv_op_t INV_ASID              = 5'd4;
    localparam inv_op_t INV_ASID_VA           = 5'd5;
    localparam inv_op_t INV_GLOBAL_OR_ASID_VA = 5'd6;

    // page-pair compare, shared by lookup and invalidation
    function automatic logic vppn_hit(
        input ps_t   entry_ps,
        input vppn_t entry_vppn,
        input vppn_t req_vppn
    );
        logic full_eq;
        logic high_eq;
        full_eq = (entry_vppn == req_vppn);
        high_eq = (entry_vppn[$bits(vppn_t)-1:HUGE_VPPN_LSB]
                   == req_vppn[$bits(vppn_t)-1:HUGE_VPPN_LSB]);
        return (entry_ps == PS_SMALL) ? full_eq : high_eq;
    endfunction

endpackage
